// ==== include/x11_defines.svh ====
`ifndef X11_DEFINES_SVH
`define X11_DEFINES_SVH

// --------------------
// global register offsets
// --------------------
`define X11_REG_CTRL        20'h00000  // global control, rw
`define X11_REG_STATUS      20'h00004  // global status, ro
`define X11_REG_VERSION     20'h0000C  // build version word, ro

// --------------------
// sha-256 register offsets
// --------------------
`define X11_REG_SHA_CTRL    20'h00100  // rw, bit 1 one-shot
`define X11_REG_SHA_STATUS  20'h00104  // ro
`define X11_REG_SHA_PUSH    20'h0010C  // wo, word into fifo
`define X11_REG_SHA_H7      20'h00110  // lsb word of hash
`define X11_REG_SHA_H6      20'h00114
`define X11_REG_SHA_H5      20'h00118
`define X11_REG_SHA_H4      20'h0011C
`define X11_REG_SHA_H3      20'h00120
`define X11_REG_SHA_H2      20'h00124
`define X11_REG_SHA_H1      20'h00128
`define X11_REG_SHA_H0      20'h0012C  // msb word of hash
`define X11_REG_SHA_COUNT   20'h00130  // fifo fill count, ro

// control bit positions
`define X11_CTRL_ENABLE     0
`define X11_SHA_ENABLE      0
`define X11_SHA_RESET       1          // self clearing
`define X11_SHA_DBL_HASH    4

// word fifo geometry
`define X11_FIFO_DEPTH      16
`define X11_FIFO_AW         4          // log2 of depth

`define X11_BLOCK_WORDS     16         // 512 bit block = 16 words

`define X11_VERSION         32'h16082101  // yymmddss

`endif

// ==== design/x11_pkg.sv ====
`include "x11_defines.svh"

package x11_pkg;

  // --------------------
  // plain vector types
  // --------------------
  typedef logic [31:0]             bus_word_t;    // bus data word
  typedef logic [19:0]             bus_addr_t;    // decoded offset
  typedef logic [255:0]            hash_t;        // H0 in the top word
  typedef logic [`X11_FIFO_AW:0]   fifo_count_t;  // one extra bit for full

  // --------------------
  // grouped signals
  // --------------------

  // sha-256 control as seen by the sequencer
  typedef struct packed {
    logic enable;    // sha enable and global enable
    logic reset;     // one-shot or global disable
    logic dbl_hash;  // sha256(sha256(x))
  } sha_ctrl_s;

  // fifo flags back to the register block
  typedef struct packed {
    logic        empty;
    logic        almost_full;  // count >= depth-1
    logic        full;
    fifo_count_t count;
  } fifo_stat_s;

  // engine side status
  typedef struct packed {
    logic activated;   // engine out of reset
    logic ready;
    logic hash_valid;
  } eng_stat_s;

  // sequencer states
  typedef enum logic [1:0] {
    ENG_OFF,   // engine held in reset
    ENG_IDLE,  // waiting for data and ready
    ENG_RUN    // block in flight
  } eng_state_e;

endpackage

// ==== design/bus_ctrl.sv ====
`timescale 1ns/1ps
`include "x11_defines.svh"

module bus_ctrl import x11_pkg::*; (
  input  logic        bus_clk,
  input  logic        bus_rstn,
  // system bus slave
  input  bus_addr_t   sys_addr_i,
  input  bus_word_t   sys_wdata_i,
  input  logic        sys_wen_i,
  input  logic        sys_ren_i,
  output bus_word_t   sys_rdata_o,
  output logic        sys_ack_o,
  output logic        sys_err_o,
  // control towards the engine side
  output logic        x11_activated_o,
  output sha_ctrl_s   sha_ctrl_o,
  output logic        push_valid_o,
  output bus_word_t   push_data_o,
  // status back from the engine side
  input  fifo_stat_s  fifo_stat_i,
  input  eng_stat_s   eng_stat_i,
  input  hash_t       hash_words_i
);

  bus_word_t ctrl_q;        // global control
  bus_word_t sha_ctrl_q;    // sha-256 control
  bus_word_t status_w;
  bus_word_t sha_status_w;
  bus_word_t rdata_d;       // read mux out
  logic      x11_enable;

  assign x11_enable      = ctrl_q[`X11_CTRL_ENABLE];
  assign x11_activated_o = x11_enable;
  assign sys_err_o       = 1'b0;  // every offset is answered

  // global disable forces the engine into reset
  assign sha_ctrl_o = '{
    enable:   sha_ctrl_q[`X11_SHA_ENABLE] & x11_enable,
    reset:    sha_ctrl_q[`X11_SHA_RESET] | ~x11_enable,
    dbl_hash: sha_ctrl_q[`X11_SHA_DBL_HASH]
  };

  // --------------------
  // register writes
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      ctrl_q       <= '0;
      sha_ctrl_q   <= '0;
      push_valid_o <= 1'b0;
    end else begin
      sha_ctrl_q[`X11_SHA_RESET] <= 1'b0;  // one-shot, high for a single cycle
      push_valid_o               <= 1'b0;
      if (sys_wen_i) begin
        case (sys_addr_i)
          `X11_REG_CTRL:     ctrl_q       <= sys_wdata_i;
          `X11_REG_SHA_CTRL: sha_ctrl_q   <= sys_wdata_i;  // a set reset bit wins this cycle
          `X11_REG_SHA_PUSH: push_valid_o <= 1'b1;
          default: ;                                       // ignored
        endcase
      end
    end
  end

  // push word, qualified by push_valid_o
  always_ff @(posedge bus_clk) begin
    if (sys_wen_i && (sys_addr_i == `X11_REG_SHA_PUSH)) begin
      push_data_o <= sys_wdata_i;
    end
  end

  // --------------------
  // read mux
  // --------------------
  always_comb begin
    status_w     = '0;
    status_w[0]  = x11_enable;
    status_w[4]  = eng_stat_i.activated;

    sha_status_w    = '0;
    sha_status_w[0] = eng_stat_i.ready;
    sha_status_w[1] = eng_stat_i.hash_valid;
    sha_status_w[4] = fifo_stat_i.empty;
    sha_status_w[5] = fifo_stat_i.almost_full;
    sha_status_w[6] = fifo_stat_i.full;

    case (sys_addr_i)
      `X11_REG_CTRL:       rdata_d = ctrl_q;
      `X11_REG_STATUS:     rdata_d = status_w;
      `X11_REG_VERSION:    rdata_d = `X11_VERSION;
      `X11_REG_SHA_CTRL:   rdata_d = sha_ctrl_q;
      `X11_REG_SHA_STATUS: rdata_d = sha_status_w;
      `X11_REG_SHA_H7:     rdata_d = hash_words_i[0*32 +: 32];  // lsb
      `X11_REG_SHA_H6:     rdata_d = hash_words_i[1*32 +: 32];
      `X11_REG_SHA_H5:     rdata_d = hash_words_i[2*32 +: 32];
      `X11_REG_SHA_H4:     rdata_d = hash_words_i[3*32 +: 32];
      `X11_REG_SHA_H3:     rdata_d = hash_words_i[4*32 +: 32];
      `X11_REG_SHA_H2:     rdata_d = hash_words_i[5*32 +: 32];
      `X11_REG_SHA_H1:     rdata_d = hash_words_i[6*32 +: 32];
      `X11_REG_SHA_H0:     rdata_d = hash_words_i[7*32 +: 32];  // msb
      `X11_REG_SHA_COUNT:  rdata_d = bus_word_t'(fifo_stat_i.count);
      default:             rdata_d = '0;  // push port and holes
    endcase
  end

  // ack one cycle after any strobe
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      sys_ack_o   <= 1'b0;
      sys_rdata_o <= '0;
    end else begin
      sys_ack_o   <= sys_wen_i | sys_ren_i;
      sys_rdata_o <= sys_ren_i ? rdata_d : '0;
    end
  end

  // every ack answers exactly one strobe, read or write, the cycle before
  a_ack_needs_strobe: assert property (
    @(posedge bus_clk) disable iff (!bus_rstn)
      sys_ack_o |-> $past(sys_wen_i ^ sys_ren_i)
  ) else $error("bus_ctrl: ack without a single preceding strobe");

endmodule

// ==== design/word_fifo.sv ====
`timescale 1ns/1ps
`include "x11_defines.svh"

module word_fifo import x11_pkg::*; (
  input  logic        bus_clk,
  input  logic        bus_rstn,
  input  logic        clear_i,       // engine in reset
  // push side, from the register block
  input  logic        push_valid_i,
  input  bus_word_t   push_data_i,
  // pop side, towards the engine
  output bus_word_t   word_o,
  output logic        word_valid_o,
  input  logic        word_ready_i,
  output fifo_stat_s  fifo_stat_o
);

  bus_word_t               mem [`X11_FIFO_DEPTH];
  logic [`X11_FIFO_AW-1:0] wr_ptr;
  logic [`X11_FIFO_AW-1:0] rd_ptr;
  fifo_count_t             count;
  logic                    push_ok;
  logic                    pop;

  assign fifo_stat_o.empty       = (count == '0);
  assign fifo_stat_o.full        = (count == fifo_count_t'(`X11_FIFO_DEPTH));
  assign fifo_stat_o.almost_full = (count >= fifo_count_t'(`X11_FIFO_DEPTH - 1));
  assign fifo_stat_o.count       = count;

  assign push_ok      = push_valid_i & ~fifo_stat_o.full;  // drop when full
  assign pop          = word_valid_o & word_ready_i;
  assign word_valid_o = ~fifo_stat_o.empty;
  assign word_o       = mem[rd_ptr];                       // head word

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || clear_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_ok) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop)     rd_ptr <= rd_ptr + 1'b1;
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                           // both or none
      endcase
    end
  end

  // storage
  always_ff @(posedge bus_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  a_count_max: assert property (
    @(posedge bus_clk) disable iff (!bus_rstn)
      count <= fifo_count_t'(`X11_FIFO_DEPTH)
  ) else $error("word_fifo: count above depth");

  // from empty the next count is 0 or 1, a wrap would show as a large value
  a_no_underflow: assert property (
    @(posedge bus_clk) disable iff (!bus_rstn)
      (count == '0) |=> (count <= fifo_count_t'(1))
  ) else $error("word_fifo: count underflow");

endmodule

// ==== design/hash_capture.sv ====
`timescale 1ns/1ps

module hash_capture import x11_pkg::*; (
  input  logic   bus_clk,
  input  logic   bus_rstn,
  input  logic   clear_i,        // engine in reset
  input  logic   hash_valid_i,
  input  hash_t  hash_i,         // H0 in [255:224]
  output hash_t  hash_words_o
);

  logic valid_d;   // delayed valid for edge detect
  logic valid_rise;

  assign valid_rise = hash_valid_i & ~valid_d;

  // --------------------
  // edge detect
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || clear_i) begin
      valid_d <= 1'b0;
    end else begin
      valid_d <= hash_valid_i;
    end
  end

  // result words, zero while the engine is off
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn || clear_i) begin
      hash_words_o <= '0;
    end else if (valid_rise) begin
      hash_words_o <= hash_i;  // held until next rising edge
    end
  end

endmodule

// ==== design/engine_sequencer.sv ====
`timescale 1ns/1ps

module engine_sequencer import x11_pkg::*; (
  input  logic       bus_clk,
  input  logic       bus_rstn,
  input  sha_ctrl_s  sha_ctrl_i,
  input  logic       fifo_empty_i,
  input  logic       eng_ready_i,
  input  logic       hash_valid_i,
  output logic       eng_rstn_o,    // low holds engine, fifo and capture clear
  output logic       eng_start_o,   // single cycle pulse
  output logic       dbl_hash_o,
  output eng_stat_s  eng_stat_o
);

  eng_state_e state;
  logic       go;   // enabled and not in reset

  assign go         = sha_ctrl_i.enable & ~sha_ctrl_i.reset;
  assign eng_rstn_o = (state != ENG_OFF);
  assign dbl_hash_o = sha_ctrl_i.dbl_hash;  // mode input for the core

  assign eng_stat_o = '{activated: eng_rstn_o, ready: eng_ready_i, hash_valid: hash_valid_i};

  // --------------------
  // state machine
  // --------------------
  always_ff @(posedge bus_clk) begin
    if (!bus_rstn) begin
      state       <= ENG_OFF;
      eng_start_o <= 1'b0;
    end else begin
      eng_start_o <= 1'b0;
      if (!go) begin
        state <= ENG_OFF;  // from any state
      end else begin
        case (state)
          ENG_OFF:  state <= ENG_IDLE;
          ENG_IDLE: if (!fifo_empty_i && eng_ready_i) begin
            state       <= ENG_RUN;
            eng_start_o <= 1'b1;  // first cycle of run
          end
          ENG_RUN:  if (hash_valid_i) state <= ENG_IDLE;  // latency varies
          default:  state <= ENG_OFF;
        endcase
      end
    end
  end

  a_start_single: assert property (
    @(posedge bus_clk) disable iff (!bus_rstn)
      eng_start_o |=> !eng_start_o
  ) else $error("engine_sequencer: start longer than one cycle");

endmodule

// ==== design/x11_regs_top.sv ====
`timescale 1ns/1ps

module x11_regs_top import x11_pkg::*; (
  input  logic       bus_clk,
  input  logic       bus_rstn,
  // system bus slave
  input  bus_addr_t  sys_addr_i,
  input  bus_word_t  sys_wdata_i,
  input  logic       sys_wen_i,
  input  logic       sys_ren_i,
  output bus_word_t  sys_rdata_o,
  output logic       sys_ack_o,
  output logic       sys_err_o,
  output logic       x11_activated_o,
  // engine side
  output bus_word_t  word_o,
  output logic       word_valid_o,
  input  logic       word_ready_i,
  output logic       eng_rstn_o,
  output logic       eng_start_o,
  output logic       dbl_hash_o,
  input  logic       eng_ready_i,
  input  logic       hash_valid_i,
  input  hash_t      hash_i
);

  sha_ctrl_s  sha_ctrl;
  logic       push_valid;
  bus_word_t  push_data;
  fifo_stat_s fifo_stat;
  eng_stat_s  eng_stat;
  hash_t      hash_words;
  logic       eng_clear;  // engine side held clear

  assign eng_clear = ~eng_rstn_o;

  // --------------------
  // register block
  // --------------------
  bus_ctrl i_bus_ctrl (
    .bus_clk         (bus_clk),
    .bus_rstn        (bus_rstn),
    .sys_addr_i      (sys_addr_i),
    .sys_wdata_i     (sys_wdata_i),
    .sys_wen_i       (sys_wen_i),
    .sys_ren_i       (sys_ren_i),
    .sys_rdata_o     (sys_rdata_o),
    .sys_ack_o       (sys_ack_o),
    .sys_err_o       (sys_err_o),
    .x11_activated_o (x11_activated_o),
    .sha_ctrl_o      (sha_ctrl),
    .push_valid_o    (push_valid),
    .push_data_o     (push_data),
    .fifo_stat_i     (fifo_stat),
    .eng_stat_i      (eng_stat),
    .hash_words_i    (hash_words)
  );

  // --------------------
  // engine side
  // --------------------
  word_fifo i_word_fifo (
    .bus_clk      (bus_clk),
    .bus_rstn     (bus_rstn),
    .clear_i      (eng_clear),
    .push_valid_i (push_valid),
    .push_data_i  (push_data),
    .word_o       (word_o),
    .word_valid_o (word_valid_o),
    .word_ready_i (word_ready_i),
    .fifo_stat_o  (fifo_stat)
  );

  hash_capture i_hash_capture (
    .bus_clk      (bus_clk),
    .bus_rstn     (bus_rstn),
    .clear_i      (eng_clear),
    .hash_valid_i (hash_valid_i),
    .hash_i       (hash_i),
    .hash_words_o (hash_words)
  );

  engine_sequencer i_engine_sequencer (
    .bus_clk      (bus_clk),
    .bus_rstn     (bus_rstn),
    .sha_ctrl_i   (sha_ctrl),
    .fifo_empty_i (fifo_stat.empty),
    .eng_ready_i  (eng_ready_i),
    .hash_valid_i (hash_valid_i),
    .eng_rstn_o   (eng_rstn_o),
    .eng_start_o  (eng_start_o),
    .dbl_hash_o   (dbl_hash_o),
    .eng_stat_o   (eng_stat)
  );

endmodule

// ==== tb/tb_x11_regs.sv ====
`timescale 1ns/1ps
`include "x11_defines.svh"

module tb_x11_regs import x11_pkg::*; ();

  // a few hundred bus accesses at most, so a wide margin
  localparam int TIMEOUT_CYCLES = `X11_BLOCK_WORDS * 1250;

  logic      bus_clk;
  logic      bus_rstn;
  bus_addr_t sys_addr_i;
  bus_word_t sys_wdata_i;
  logic      sys_wen_i;
  logic      sys_ren_i;
  bus_word_t sys_rdata_o;
  logic      sys_ack_o;
  logic      sys_err_o;
  logic      x11_activated_o;
  bus_word_t word_o;
  logic      word_valid_o;
  logic      word_ready_i;
  logic      eng_rstn_o;
  logic      eng_start_o;
  logic      dbl_hash_o;
  logic      eng_ready_i;
  logic      hash_valid_i;
  hash_t     hash_i;

  int        cycles      = 0;
  int        start_count = 0;  // start pulses seen
  bus_word_t model_q [$];      // expected fifo contents
  bus_word_t block_words [`X11_BLOCK_WORDS];
  bus_word_t model_ctrl;
  bus_word_t model_sha_ctrl;
  hash_t     exp_hash;

  x11_regs_top i_x11_regs_top (.*);

  initial begin
    bus_clk = 1'b0;
    forever #10 bus_clk = ~bus_clk;
  end

  always @(posedge bus_clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) stop_with_error("timeout, the run did not finish in time");
  end

  always @(negedge bus_clk) if (eng_start_o) start_count++;  // mid-cycle sample

  // --------------------
  // reporting and checks
  // --------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_word(input bus_word_t got, input bus_word_t exp, input string what);
    if (got !== exp)
      stop_with_error($sformatf("MISMATCH at %0t ns: %s got %08h expected %08h",
                                $time, what, got, exp));
  endtask

  task automatic compare_hash(input hash_t got, input hash_t exp, input string what);
    if (got !== exp)
      stop_with_error($sformatf("MISMATCH at %0t ns: %s got %064h expected %064h",
                                $time, what, got, exp));
  endtask

  task automatic compare_count(input fifo_count_t got, input fifo_count_t exp,
                               input string what);
    if (got !== exp)
      stop_with_error($sformatf("MISMATCH at %0t ns: %s got %0d expected %0d",
                                $time, what, got, exp));
  endtask

  // --------------------
  // bus tasks
  // --------------------
  task automatic bus_access(input logic wr, input bus_addr_t addr, input bus_word_t data,
                            output bus_word_t rdata);
    int waited;
    @(posedge bus_clk);
    sys_addr_i  <= addr;
    sys_wdata_i <= data;
    sys_wen_i   <= wr;
    sys_ren_i   <= !wr;
    @(posedge bus_clk);
    sys_wen_i <= 1'b0;  // single cycle strobe
    sys_ren_i <= 1'b0;
    waited = 0;
    @(negedge bus_clk);
    while (!sys_ack_o) begin
      waited++;
      if (waited > 4) stop_with_error($sformatf("no acknowledge for access at %05h", addr));
      @(negedge bus_clk);
    end
    rdata = sys_rdata_o;
    compare_word(bus_word_t'(sys_err_o), 32'd0, "sys_err_o on ack");
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_word_t data);
    bus_word_t unused;
    bus_access(1'b1, addr, data, unused);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_word_t data);
    bus_access(1'b0, addr, '0, data);
  endtask

  task automatic check_read(input bus_addr_t addr, input bus_word_t exp, input string what);
    bus_word_t got;
    bus_read(addr, got);
    compare_word(got, exp, what);
  endtask

  task automatic read_hash(output hash_t h);
    bus_word_t w;
    for (int i = 0; i < 8; i++) begin
      bus_read(bus_addr_t'(`X11_REG_SHA_H0 - 4 * i), w);  // H0 first, down to H7
      h[(7 - i) * 32 +: 32] = w;
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  task automatic push_word(input bus_word_t w);
    bus_write(`X11_REG_SHA_PUSH, w);
    if (model_q.size() < `X11_FIFO_DEPTH) model_q.push_back(w);  // dropped when full
  endtask

  function automatic bus_word_t sha_status_exp(input int n, input logic ready);
    bus_word_t s;
    s    = '0;
    s[0] = ready;
    s[4] = (n == 0);
    s[5] = (n >= `X11_FIFO_DEPTH - 1);
    s[6] = (n == `X11_FIFO_DEPTH);
    return s;
  endfunction

  // Hi is the xor of all block words, word j rotated left by i+j
  function automatic hash_t block_hash();
    hash_t     h;
    bus_word_t acc;
    int        s;
    h = '0;
    for (int i = 0; i < 8; i++) begin
      acc = '0;
      for (int j = 0; j < `X11_BLOCK_WORDS; j++) begin
        s   = (i + j) % 32;
        acc = acc ^ ((block_words[j] << s) | (block_words[j] >> (32 - s)));
      end
      h[(7 - i) * 32 +: 32] = acc;  // H0 on top
    end
    return h;
  endfunction

  task automatic check_activation(input logic g, input logic s);
    bus_word_t exp;
    bus_write(`X11_REG_CTRL, bus_word_t'(g));
    bus_write(`X11_REG_SHA_CTRL, bus_word_t'(s));
    exp    = '0;
    exp[0] = g;
    exp[4] = g & s;
    check_read(`X11_REG_STATUS, exp, "global status activation");
    compare_word(bus_word_t'(x11_activated_o), bus_word_t'(g), "x11_activated_o");
    compare_word(bus_word_t'(eng_rstn_o), bus_word_t'(g & s), "eng_rstn_o");
  endtask

  // --------------------
  // engine model
  // --------------------
  task automatic run_engine_block();
    int        popped;
    int        waited;
    bus_word_t w;
    @(posedge bus_clk);
    eng_ready_i <= 1'b1;
    waited = 0;
    @(negedge bus_clk);
    while (!eng_start_o) begin
      waited++;
      if (waited > 10) stop_with_error("engine start pulse never came");
      @(negedge bus_clk);
    end
    @(posedge bus_clk);
    eng_ready_i <= 1'b0;  // busy with the block
    popped = 0;
    while (popped < `X11_BLOCK_WORDS) begin
      @(posedge bus_clk);
      word_ready_i <= ($urandom % 3) != 0;  // random back-pressure
      @(negedge bus_clk);
      compare_word(bus_word_t'(word_valid_o), bus_word_t'(model_q.size() != 0),
                   "word_valid_o");
      if (word_ready_i && word_valid_o) begin  // transfers at next edge
        w = model_q.pop_front();
        compare_word(word_o, w, "engine word order");
        block_words[popped] = w;
        popped++;
      end
    end
    @(posedge bus_clk);
    word_ready_i <= 1'b0;
    exp_hash = block_hash();
    repeat (1 + $urandom % 8) @(posedge bus_clk);  // varying latency
    hash_i       <= exp_hash;
    hash_valid_i <= 1'b1;
    @(posedge bus_clk);
    hash_valid_i <= 1'b0;
  endtask

  // --------------------
  // test sequence
  // --------------------
  initial begin
    bus_word_t d;
    hash_t     h;
    void'($urandom(59));
    bus_rstn     <= 1'b0;
    sys_addr_i   <= '0;
    sys_wdata_i  <= '0;
    sys_wen_i    <= 1'b0;
    sys_ren_i    <= 1'b0;
    word_ready_i <= 1'b0;
    eng_ready_i  <= 1'b0;
    hash_valid_i <= 1'b0;
    hash_i       <= '0;
    model_ctrl     = '0;
    model_sha_ctrl = '0;
    repeat (3) @(posedge bus_clk);
    bus_rstn <= 1'b1;
    @(negedge bus_clk);
    compare_word(bus_word_t'(sys_ack_o), 32'd0, "sys_ack_o after reset");
    compare_word(bus_word_t'(eng_start_o), 32'd0, "eng_start_o after reset");
    compare_word(bus_word_t'(eng_rstn_o), 32'd0, "eng_rstn_o after reset");

    // reset values, readback, version, holes
    check_read(`X11_REG_CTRL, '0, "ctrl after reset");
    check_read(`X11_REG_STATUS, '0, "status after reset");
    check_read(`X11_REG_SHA_CTRL, '0, "sha ctrl after reset");
    check_read(`X11_REG_SHA_STATUS, sha_status_exp(0, 1'b0), "sha status after reset");
    bus_read(`X11_REG_SHA_COUNT, d);
    compare_count(fifo_count_t'(d), '0, "count after reset");
    read_hash(h);
    compare_hash(h, '0, "hash after reset");
    check_read(`X11_REG_VERSION, `X11_VERSION, "version word");
    repeat (20) begin
      d = $urandom;
      if ($urandom % 2) begin
        bus_write(`X11_REG_CTRL, d);
        model_ctrl = d;
      end else begin
        bus_write(`X11_REG_SHA_CTRL, d);
        model_sha_ctrl = d & ~(32'h1 << `X11_SHA_RESET);  // one-shot gone by readback
      end
      check_read(`X11_REG_CTRL, model_ctrl, "ctrl readback");
      check_read(`X11_REG_SHA_CTRL, model_sha_ctrl, "sha ctrl readback");
    end
    bus_write(20'h00200, $urandom);  // ignored
    check_read(20'h00200, '0, "unknown address");
    check_read(20'h00108, '0, "register hole");
    check_read(`X11_REG_CTRL, model_ctrl, "ctrl after unknown write");

    // one-shot reset and activation
    bus_write(`X11_REG_CTRL, 32'h1);
    bus_write(`X11_REG_SHA_CTRL, 32'h3);  // enable with reset
    check_read(`X11_REG_SHA_CTRL, 32'h1, "sha reset self clear");
    check_read(`X11_REG_STATUS, 32'h11, "status after engine reset");
    check_activation(1'b1, 1'b0);
    check_activation(1'b1, 1'b1);
    check_activation(1'b0, 1'b1);
    check_activation(1'b1, 1'b1);

    // fill while the engine is not ready
    model_q.delete();
    repeat (`X11_FIFO_DEPTH + 4) begin
      push_word($urandom);
      bus_read(`X11_REG_SHA_COUNT, d);
      compare_count(fifo_count_t'(d), fifo_count_t'(model_q.size()), "fill count");
      check_read(`X11_REG_SHA_STATUS, sha_status_exp(model_q.size(), 1'b0), "fifo flags");
    end
    compare_word(bus_word_t'(start_count), 32'd0, "start pulses while not ready");

    // one block through the engine
    bus_write(`X11_REG_SHA_CTRL, 32'h11);  // enable and double hash
    compare_word(bus_word_t'(dbl_hash_o), 32'd1, "dbl_hash_o set");
    run_engine_block();
    compare_word(bus_word_t'(start_count), 32'd1, "start pulses per block");

    // captured hash, then cleared by disable
    read_hash(h);
    compare_hash(h, exp_hash, "captured hash");
    check_read(`X11_REG_SHA_STATUS, sha_status_exp(0, 1'b0), "status after block");
    bus_write(`X11_REG_SHA_CTRL, 32'h1);
    compare_word(bus_word_t'(dbl_hash_o), 32'd0, "dbl_hash_o clear");
    bus_write(`X11_REG_SHA_CTRL, 32'h0);
    @(posedge bus_clk);  // capture clears one cycle after the engine drops
    read_hash(h);
    compare_hash(h, '0, "hash after disable");
    compare_word(bus_word_t'(start_count), 32'd1, "start pulses at end");

    $display("Done: no errors");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
design/x11_pkg.sv
design/bus_ctrl.sv
design/word_fifo.sv
design/hash_capture.sv
design/engine_sequencer.sv
design/x11_regs_top.sv
tb/tb_x11_regs.sv
